//--- rtl/axi_pkg.sv
`default_nettype none

package axi_pkg;

  // Master-side ID width
  localparam int ID_BITS = 4;

  // Master field sits in the top bits of the extended ID
  localparam int MSEL_BITS = 2;
  localparam int IDS_BITS = ID_BITS + MSEL_BITS;

  localparam int RESP_BITS = 2;
  localparam int NUM_SLAVES = 3;

  // Arbiter lock state, one value per slave plus idle
  typedef enum logic [1:0] {
    LOCK_NO = 2'd0,
    LOCK_S0 = 2'd1,
    LOCK_S1 = 2'd2,
    LOCK_S2 = 2'd3
  } lock_state_t;

  // Decode result, MASTER_U for fields that name no master
  typedef enum logic [1:0] {
    MASTER_0 = 2'd0,
    MASTER_1 = 2'd1,
    MASTER_U = 2'd2
  } master_sel_t;

  function automatic master_sel_t master_decode(input logic [IDS_BITS-1:0] id);
    logic [MSEL_BITS-1:0] field;
    master_sel_t sel;
    field = id[IDS_BITS-1 -: MSEL_BITS];
    case (field)
      2'd0:    sel = MASTER_0;
      2'd1:    sel = MASTER_1;
      default: sel = MASTER_U; // Values 2 and 3 are dropped
    endcase
    return sel;
  endfunction

endpackage

`default_nettype wire

//--- rtl/b_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

interface b_chan_if
  import axi_pkg::*;
();

  logic [IDS_BITS-1:0]  id;
  logic [RESP_BITS-1:0] resp;
  logic                 valid;
  logic                 ready;

  modport source (
    output id,
    output resp,
    output valid,
    input  ready
  );

  modport sink (
    input  id,
    input  resp,
    input  valid,
    output ready
  );

endinterface

`default_nettype wire

//--- rtl/b_slave_capture.sv
`timescale 1ns/1ps
`default_nettype none

module b_slave_capture
  import axi_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  input  logic [IDS_BITS-1:0]  s_id,
  input  logic [RESP_BITS-1:0] s_resp,
  input  logic                 s_valid,
  output logic                 s_ready,
  b_chan_if.source             out
);

  logic                 full;
  logic [IDS_BITS-1:0]  id_q;
  logic [RESP_BITS-1:0] resp_q;
  logic                 load;
  logic                 take;

  assign s_ready = !full; // Accept only into an empty slot
  assign load    = s_valid && s_ready;
  assign take    = out.valid && out.ready;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (take) begin
      full <= 1'b0;
    end
  end

  // Payload stays put while full
  always_ff @(posedge clk) begin
    if (load) begin
      id_q   <= s_id;
      resp_q <= s_resp;
    end
  end

  assign out.valid = full;
  assign out.id    = id_q;
  assign out.resp  = resp_q;

endmodule

`default_nettype wire

//--- rtl/b_lock_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module b_lock_arbiter
  import axi_pkg::*;
(
  input  logic   clk,
  input  logic   rstn,
  b_chan_if.sink in0,
  b_chan_if.sink in1,
  b_chan_if.sink in2,
  b_chan_if.source out
);

  lock_state_t lock;
  lock_state_t lock_next;
  logic        xfer;

  assign xfer = out.valid && out.ready;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock <= LOCK_NO;
    end else begin
      lock <= lock_next;
    end
  end

  // Hold the lock until the output handshake, then look past the current slave
  always_comb begin
    lock_next = lock;
    unique case (lock)
      LOCK_NO: begin
        if (in0.valid) begin
          lock_next = LOCK_S0;
        end else if (in1.valid) begin
          lock_next = LOCK_S1;
        end else if (in2.valid) begin
          lock_next = LOCK_S2;
        end
      end
      LOCK_S0: begin
        if (xfer) begin
          lock_next = in1.valid ? LOCK_S1 : (in2.valid ? LOCK_S2 : LOCK_NO);
        end
      end
      LOCK_S1: begin
        if (xfer) begin
          lock_next = in2.valid ? LOCK_S2 : (in0.valid ? LOCK_S0 : LOCK_NO);
        end
      end
      LOCK_S2: begin
        if (xfer) begin
          lock_next = in0.valid ? LOCK_S0 : (in1.valid ? LOCK_S1 : LOCK_NO);
        end
      end
    endcase
  end

  // Output mux and ready return, nothing goes out while idle
  always_comb begin
    out.valid = 1'b0;
    out.id    = '0;
    out.resp  = '0;
    in0.ready = 1'b0;
    in1.ready = 1'b0;
    in2.ready = 1'b0;
    unique case (lock)
      LOCK_S0: begin
        out.valid = in0.valid;
        out.id    = in0.id;
        out.resp  = in0.resp;
        in0.ready = out.ready;
      end
      LOCK_S1: begin
        out.valid = in1.valid;
        out.id    = in1.id;
        out.resp  = in1.resp;
        in1.ready = out.ready;
      end
      LOCK_S2: begin
        out.valid = in2.valid;
        out.id    = in2.id;
        out.resp  = in2.resp;
        in2.ready = out.ready;
      end
      LOCK_NO: ;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/b_master_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module b_master_decoder
  import axi_pkg::*;
(
  b_chan_if.sink               in,
  output logic [ID_BITS-1:0]   m0_id,
  output logic [RESP_BITS-1:0] m0_resp,
  output logic                 m0_valid,
  input  logic                 m0_ready,
  output logic [ID_BITS-1:0]   m1_id,
  output logic [RESP_BITS-1:0] m1_resp,
  output logic                 m1_valid,
  input  logic                 m1_ready
);

  master_sel_t sel;

  assign sel = master_decode(in.id);

  // Payload goes to both, only valid is steered
  assign m0_id   = in.id[ID_BITS-1:0];
  assign m0_resp = in.resp;
  assign m1_id   = in.id[ID_BITS-1:0];
  assign m1_resp = in.resp;

  always_comb begin
    m0_valid = 1'b0;
    m1_valid = 1'b0;
    in.ready = 1'b0;
    case (sel)
      MASTER_0: begin
        m0_valid = in.valid;
        in.ready = m0_ready;
      end
      MASTER_1: begin
        m1_valid = in.valid;
        in.ready = m1_ready;
      end
      default: begin
        in.ready = 1'b1; // Unassigned, drain it
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/axi_b_router.sv
`timescale 1ns/1ps
`default_nettype none

module axi_b_router
  import axi_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  // Slave 0
  input  logic [IDS_BITS-1:0]  s0_id,
  input  logic [RESP_BITS-1:0] s0_resp,
  input  logic                 s0_valid,
  output logic                 s0_ready,
  // Slave 1
  input  logic [IDS_BITS-1:0]  s1_id,
  input  logic [RESP_BITS-1:0] s1_resp,
  input  logic                 s1_valid,
  output logic                 s1_ready,
  // Slave 2
  input  logic [IDS_BITS-1:0]  s2_id,
  input  logic [RESP_BITS-1:0] s2_resp,
  input  logic                 s2_valid,
  output logic                 s2_ready,
  // Master 0
  output logic [ID_BITS-1:0]   m0_id,
  output logic [RESP_BITS-1:0] m0_resp,
  output logic                 m0_valid,
  input  logic                 m0_ready,
  // Master 1
  output logic [ID_BITS-1:0]   m1_id,
  output logic [RESP_BITS-1:0] m1_resp,
  output logic                 m1_valid,
  input  logic                 m1_ready
);

  b_chan_if cap_if0 ();
  b_chan_if cap_if1 ();
  b_chan_if cap_if2 ();
  b_chan_if arb_if ();

  b_slave_capture cap0_i (
    .clk(clk), .rstn(rstn),
    .s_id(s0_id), .s_resp(s0_resp), .s_valid(s0_valid), .s_ready(s0_ready),
    .out(cap_if0.source)
  );

  b_slave_capture cap1_i (
    .clk(clk), .rstn(rstn),
    .s_id(s1_id), .s_resp(s1_resp), .s_valid(s1_valid), .s_ready(s1_ready),
    .out(cap_if1.source)
  );

  b_slave_capture cap2_i (
    .clk(clk), .rstn(rstn),
    .s_id(s2_id), .s_resp(s2_resp), .s_valid(s2_valid), .s_ready(s2_ready),
    .out(cap_if2.source)
  );

  b_lock_arbiter arb_i (
    .clk (clk),
    .rstn(rstn),
    .in0 (cap_if0.sink),
    .in1 (cap_if1.sink),
    .in2 (cap_if2.sink),
    .out (arb_if.source)
  );

  // Combinational, no added latency
  b_master_decoder dec_i (
    .in      (arb_if.sink),
    .m0_id   (m0_id),
    .m0_resp (m0_resp),
    .m0_valid(m0_valid),
    .m0_ready(m0_ready),
    .m1_id   (m1_id),
    .m1_resp (m1_resp),
    .m1_valid(m1_valid),
    .m1_ready(m1_ready)
  );

endmodule

`default_nettype wire

//--- tests/b_router_checker.sv
`timescale 1ns/1ps
`default_nettype none

module b_router_checker
  import axi_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rstn,
  input  logic [NUM_SLAVES-1:0]                s_ready,
  input  logic [NUM_SLAVES-1:0]                push,
  input  int                                   exp_tgt [NUM_SLAVES],
  input  logic [NUM_SLAVES-1:0][ID_BITS-1:0]   exp_id,
  input  logic [NUM_SLAVES-1:0][RESP_BITS-1:0] exp_resp,
  input  logic [1:0]                           m_valid,
  input  logic [1:0]                           m_ready,
  input  logic [1:0][ID_BITS-1:0]              m_id,
  input  logic [1:0][RESP_BITS-1:0]            m_resp,
  output int                                   error_count,
  output int                                   pending
);

  localparam int DATA_BITS   = ID_BITS + RESP_BITS;
  localparam int STUCK_LIMIT = 64;

  // Entry is drop flag, master, ID, response
  logic [DATA_BITS+1:0]          q [NUM_SLAVES][$];
  logic [1:0]                    held;
  logic [1:0][DATA_BITS-1:0]     held_data;
  int                            low_cycles [NUM_SLAVES];

  // Heads of different slaves never collide, ID bits 3:2 carry the slave
  task automatic match_transfer(input int m);
    int                   hit;
    int                   first;
    logic [DATA_BITS-1:0] act;
    hit   = -1;
    first = -1;
    act   = {m_id[m], m_resp[m]};
    for (int k = 0; k < NUM_SLAVES; k++) begin
      while (q[k].size() > 0 && q[k][0][DATA_BITS+1]) begin
        void'(q[k].pop_front()); // Drained earlier, never shows up
      end
      if (q[k].size() > 0 && q[k][0][DATA_BITS] == 1'(m)) begin
        if (first < 0) first = k;
        if (q[k][0][DATA_BITS-1:0] == act) hit = k;
      end
    end
    if (hit >= 0) begin
      void'(q[hit].pop_front());
    end else if (first >= 0) begin
      error_count++;
      $display("Mismatch route_m%0d: expected id/resp %h actual id/resp %h",
               m, q[first][0][DATA_BITS-1:0], act);
    end else begin
      error_count++;
      $display("Master %0d took response %h that no slave sent to it", m, act);
    end
  endtask

  always @(posedge clk) begin
    if (!rstn) begin
      held        = '0;
      error_count = 0;
      pending     = 0;
      for (int k = 0; k < NUM_SLAVES; k++) low_cycles[k] = 0;
    end else begin
      for (int m = 0; m < 2; m++) begin
        if (held[m] && (!m_valid[m] || {m_id[m], m_resp[m]} != held_data[m])) begin
          error_count++;
          $display("Mismatch hold_m%0d: expected valid 1 id/resp %h actual valid %b id/resp %h",
                   m, held_data[m], m_valid[m], {m_id[m], m_resp[m]});
        end
        held[m]      = m_valid[m] && !m_ready[m];
        held_data[m] = {m_id[m], m_resp[m]};
        if (m_valid[m] && m_ready[m]) match_transfer(m);
      end
      for (int k = 0; k < NUM_SLAVES; k++) begin
        if (push[k]) q[k].push_back({exp_tgt[k] < 0, 1'(exp_tgt[k]), exp_id[k], exp_resp[k]});
        low_cycles[k] = s_ready[k] ? 0 : low_cycles[k] + 1;
        if (low_cycles[k] == STUCK_LIMIT) begin
          error_count++;
          $display("Slave %0d ready stayed low for %0d cycles, its response is stuck",
                   k, STUCK_LIMIT);
        end
      end
      pending = 0; // Routed entries still waiting for a master
      for (int k = 0; k < NUM_SLAVES; k++) begin
        for (int i = 0; i < q[k].size(); i++) begin
          if (!q[k][i][DATA_BITS+1]) pending++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_axi_b_router.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_b_router
  import axi_pkg::*;
();

  localparam int NUM_RANDOM = 300;
  localparam int NUM_RESP   = NUM_RANDOM + 6; // Directed ones too
  localparam int WATCHDOG   = NUM_RESP * 20 + 200;

  logic                                 clk;
  logic                                 rstn;
  logic [NUM_SLAVES-1:0]                s_valid;
  logic [NUM_SLAVES-1:0]                s_ready;
  logic [IDS_BITS-1:0]                  s_id [NUM_SLAVES];
  logic [RESP_BITS-1:0]                 s_resp [NUM_SLAVES];
  logic [1:0]                           m_valid;
  logic [1:0]                           m_ready;
  logic [1:0][ID_BITS-1:0]              m_id;
  logic [1:0][RESP_BITS-1:0]            m_resp;
  logic [NUM_SLAVES-1:0]                push;
  int                                   exp_tgt [NUM_SLAVES];
  logic [NUM_SLAVES-1:0][ID_BITS-1:0]   exp_id;
  logic [NUM_SLAVES-1:0][RESP_BITS-1:0] exp_resp;
  int                                   error_count;
  int                                   pending;
  int                                   tb_errors;
  int                                   seed;

  axi_b_router axi_b_router_i (
    .clk(clk), .rstn(rstn),
    .s0_id(s_id[0]), .s0_resp(s_resp[0]), .s0_valid(s_valid[0]), .s0_ready(s_ready[0]),
    .s1_id(s_id[1]), .s1_resp(s_resp[1]), .s1_valid(s_valid[1]), .s1_ready(s_ready[1]),
    .s2_id(s_id[2]), .s2_resp(s_resp[2]), .s2_valid(s_valid[2]), .s2_ready(s_ready[2]),
    .m0_id(m_id[0]), .m0_resp(m_resp[0]), .m0_valid(m_valid[0]), .m0_ready(m_ready[0]),
    .m1_id(m_id[1]), .m1_resp(m_resp[1]), .m1_valid(m_valid[1]), .m1_ready(m_ready[1])
  );

  b_router_checker b_router_checker_i (
    .clk(clk), .rstn(rstn), .s_ready(s_ready), .push(push),
    .exp_tgt(exp_tgt), .exp_id(exp_id), .exp_resp(exp_resp),
    .m_valid(m_valid), .m_ready(m_ready), .m_id(m_id), .m_resp(m_resp),
    .error_count(error_count), .pending(pending)
  );

  // Returns -1 when the top two bits name no master
  function automatic int expected_route(input logic [IDS_BITS-1:0] ext_id,
                                        output logic [ID_BITS-1:0] m_id_out);
    int field;
    field    = int'(ext_id >> ID_BITS);
    m_id_out = ext_id[ID_BITS-1:0];
    if (field == 0 || field == 1) return field;
    return -1;
  endfunction

  always_comb begin
    for (int k = 0; k < NUM_SLAVES; k++) begin
      push[k]     = s_valid[k] && s_ready[k];
      exp_tgt[k]  = expected_route(s_id[k], exp_id[k]);
      exp_resp[k] = s_resp[k];
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
    $display("Simulation FAILED");
    $finish;
  end

  // Drive one response and return after its handshake edge
  task automatic send_one(input int k, input logic [IDS_BITS-1:0] ext_id,
                          input logic [RESP_BITS-1:0] resp);
    @(negedge clk);
    s_valid[k] = 1'b1;
    s_id[k]    = ext_id;
    s_resp[k]  = resp;
    @(posedge clk);
    @(negedge clk);
    s_valid[k] = 1'b0;
  endtask

  task automatic drop_check(input int k, input logic [MSEL_BITS-1:0] field);
    int   cycles;
    logic back;
    send_one(k, {field, 2'(k), 2'b10}, 2'b01);
    cycles = 0;
    back   = 1'b0;
    while (!back && cycles < 4) begin
      @(negedge clk);
      cycles++;
      back = s_ready[k];
      if (m_valid != 2'b00) begin
        tb_errors++;
        $display("Unassigned ID from slave %0d showed up on a master", k);
      end
    end
    if (!back) begin
      tb_errors++;
      $display("Slave %0d ready did not return within 4 cycles after an unassigned ID", k);
    end
  endtask

  initial begin
    int                    sent;
    int                    cycles;
    int                    got;
    logic                  seen;
    logic [NUM_SLAVES-1:0] went;
    seed      = 32'h6f61_aee1;
    tb_errors = 0;
    rstn      = 1'b0;
    s_valid   = '0;
    m_ready   = '0;
    for (int k = 0; k < NUM_SLAVES; k++) begin
      s_id[k]   = '0;
      s_resp[k] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    if (m_valid !== 2'b00 || s_ready !== 3'b111) begin
      tb_errors++;
      $display("Mismatch reset_state: expected %b actual %b", 5'b00111, {m_valid, s_ready});
    end

    m_ready = 2'b11;
    send_one(0, {2'b00, 2'd0, 2'b01}, 2'b00);
    cycles = 1; // send_one returns one cycle after the handshake cycle
    seen   = m_valid[0];
    while (!seen && cycles < 10) begin
      @(negedge clk);
      cycles++;
      seen = m_valid[0];
    end
    if (cycles != 2) begin
      tb_errors++;
      $display("Mismatch latency: expected 2 actual %0d", cycles);
    end

    // Grant starts at S0 with all three buffers full at once
    repeat (3) @(negedge clk);
    for (int k = 0; k < NUM_SLAVES; k++) begin
      s_valid[k] = 1'b1;
      s_id[k]    = {2'b00, 2'(k), 2'b11};
      s_resp[k]  = 2'(k);
    end
    @(posedge clk);
    @(negedge clk);
    s_valid = '0;
    got     = 0;
    cycles  = 0;
    while (got < NUM_SLAVES && cycles < 12) begin
      @(negedge clk);
      cycles++;
      if (m_valid[0] && m_ready[0]) begin
        if (m_id[0][3:2] != 2'(got)) begin
          tb_errors++;
          $display("Mismatch rotation: expected slave %0d actual slave %0d", got, m_id[0][3:2]);
        end
        got++;
      end
    end
    if (got < NUM_SLAVES) begin
      tb_errors++;
      $display("Rotation test saw only %0d of %0d responses", got, NUM_SLAVES);
    end

    drop_check(1, 2'd2);
    drop_check(2, 2'd3);

    sent = 0;
    went = '0;
    while (sent < NUM_RANDOM || s_valid != '0) begin
      @(negedge clk);
      for (int k = 0; k < NUM_SLAVES; k++) begin
        if (went[k] || !s_valid[k]) begin // Hold until the handshake
          s_valid[k] = (sent < NUM_RANDOM) ? 1'($random(seed)) : 1'b0;
          s_id[k]    = {2'($random(seed)), 2'(k), 2'($random(seed))};
          s_resp[k]  = 2'($random(seed));
        end
      end
      for (int m = 0; m < 2; m++) m_ready[m] = (2'($random(seed)) != 2'd0);
      for (int k = 0; k < NUM_SLAVES; k++) begin
        went[k] = s_valid[k] && s_ready[k];
        if (went[k]) sent++;
      end
    end

    m_ready = 2'b11;
    cycles  = 0;
    while (pending != 0 && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    if (pending != 0) begin
      tb_errors++;
      $display("%0d responses never reached their master", pending);
    end
    $display("Errors: checker %0d, directed %0d", error_count, tb_errors);
    if (error_count == 0 && tb_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
rtl/axi_pkg.sv
rtl/b_chan_if.sv
rtl/b_slave_capture.sv
rtl/b_lock_arbiter.sv
rtl/b_master_decoder.sv
rtl/axi_b_router.sv
tests/b_router_checker.sv
tests/tb_axi_b_router.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_axi_b_router -f src.f -o tb_axi_b_router
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_axi_b_router)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation binary returned status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1
